// File: design/memtest_consts.svh
`ifndef MEMTEST_CONSTS_SVH
`define MEMTEST_CONSTS_SVH

// Memory line and address widths
`define MEMTEST_DATA_W 256
`define MEMTEST_ADDR_W 28

// Lines written and read back in one pass
`define MEMTEST_LINES 16

// Address step between consecutive lines
`define MEMTEST_STRIDE 8

// Idle cycles between two memory commands
`define MEMTEST_GAP 2

`endif

// File: design/memtest_pkg.sv
`default_nettype none
`include "memtest_consts.svh"

package memtest_pkg;

	// One memory line, its address and its position in a pass
	typedef logic [`MEMTEST_DATA_W-1:0] line_t;
	typedef logic [`MEMTEST_ADDR_W-1:0] mem_addr_t;
	typedef logic [$clog2(`MEMTEST_LINES)-1:0] line_idx_t;

	// Gap states remember which command comes next
	typedef enum logic [2:0] {
		IDLE,
		WRITE,
		READ,
		WAIT_GAP_WR,
		WAIT_GAP_RD,
		PASS_END
	} memtest_state_t;

	// Base words, picked by line index mod 4
	localparam logic [31:0] PATTERN_SEEDS [4] = '{
		32'hA5A5_0000,
		32'h3C3C_1000,
		32'h0F0F_2000,
		32'h5A5A_3000
	};

endpackage

`default_nettype wire

// File: design/gap_timer.sv
`timescale 1ns/1ps
`default_nettype none
`include "memtest_consts.svh"

module gap_timer #(
	parameter int GAP_CYCLES = `MEMTEST_GAP
)
(
	input  logic clk,
	input  logic rst,
	input  logic timer_start,
	output logic gap_done
);

	localparam int CNT_W = $clog2(GAP_CYCLES + 1);

	logic [CNT_W-1:0] cnt;
	logic             busy;

	// Last counted cycle of the gap
	assign gap_done = busy && (cnt == '0);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt  <= '0;
			busy <= 1'b0;
		end
		else if (timer_start)
		begin
			cnt  <= CNT_W'(GAP_CYCLES - 1);
			busy <= 1'b1;
		end
		else if (busy)
		begin
			if (cnt == '0)
				busy <= 1'b0;
			else
				cnt <= cnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "memtest_consts.svh"

module pattern_gen
(
	input  memtest_pkg::line_idx_t line_idx,
	output memtest_pkg::line_t     pattern
);

	localparam int WORDS = `MEMTEST_DATA_W / 32;

	logic [31:0] seed;
	logic [31:0] line_base;

	////////////////////////////////////////////////////////////
	// Expected line contents
	////////////////////////////////////////////////////////////

	// Seed repeats every four lines
	assign seed = memtest_pkg::PATTERN_SEEDS[line_idx[1:0]];

	// Line index lands in bits 8 and up of each word
	assign line_base = 32'(line_idx) << 8;

	always_comb
	begin
		pattern = '0;
		for (int j = 0; j < WORDS; j++)
		begin
			// Word 0 in the low bits, wraps mod 2^32
			pattern[j*32 +: 32] = seed + line_base + 32'(j);
		end
	end

endmodule

`default_nettype wire

// File: design/readback_checker.sv
`timescale 1ns/1ps
`default_nettype none

module readback_checker
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  read_done,
	input  memtest_pkg::line_t     rdata,
	input  memtest_pkg::line_t     expected,
	input  memtest_pkg::mem_addr_t addr,
	output logic                  error,
	output memtest_pkg::mem_addr_t fail_addr
);

	logic mismatch;

	// Only meaningful in the cycle a read completes
	assign mismatch = read_done && (rdata != expected);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			error     <= 1'b0;
			fail_addr <= '0;
		end
		else if (mismatch && !error)
		begin
			// First failure wins, later ones are dropped
			error     <= 1'b1;
			fail_addr <= addr;
		end
	end

endmodule

`default_nettype wire

// File: design/memtest_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "memtest_consts.svh"

module memtest_fsm
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  run,
	input  logic                  mem_ready,
	input  logic                  gap_done,
	output logic                  timer_start,
	output logic                  mem_valid,
	output logic                  mem_rw,
	output memtest_pkg::line_idx_t line_idx,
	output logic                  read_done,
	output logic                  pass_done
);

	localparam memtest_pkg::line_idx_t LAST_LINE =
		memtest_pkg::line_idx_t'(`MEMTEST_LINES - 1);

	memtest_pkg::memtest_state_t state;
	logic                        run_q;
	logic                        cmd_done;

	// Command completes when the memory answers a valid
	assign mem_valid   = (state == memtest_pkg::WRITE) || (state == memtest_pkg::READ);
	assign mem_rw      = (state == memtest_pkg::WRITE);
	assign cmd_done    = mem_valid && mem_ready;
	assign timer_start = cmd_done;
	assign read_done   = (state == memtest_pkg::READ) && mem_ready;
	assign pass_done   = (state == memtest_pkg::PASS_END);

	////////////////////////////////////////////////////////////
	// Pass sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= memtest_pkg::IDLE;
			line_idx <= '0;
			run_q    <= 1'b0;
		end
		else
		begin
			run_q <= run;
			case (state)
				memtest_pkg::IDLE:
				begin
					line_idx <= '0;
					// Start one edge after run is first seen
					if (run_q)
						state <= memtest_pkg::WRITE;
				end
				memtest_pkg::WRITE:
				begin
					if (mem_ready)
					begin
						if (line_idx == LAST_LINE)
						begin
							line_idx <= '0;
							state    <= memtest_pkg::WAIT_GAP_RD;
						end
						else
						begin
							line_idx <= line_idx + 1'b1;
							state    <= memtest_pkg::WAIT_GAP_WR;
						end
					end
				end
				memtest_pkg::READ:
				begin
					if (mem_ready)
					begin
						if (line_idx == LAST_LINE)
						begin
							line_idx <= '0;
							state    <= memtest_pkg::PASS_END;
						end
						else
						begin
							line_idx <= line_idx + 1'b1;
							state    <= memtest_pkg::WAIT_GAP_RD;
						end
					end
				end
				memtest_pkg::WAIT_GAP_WR:
				begin
					if (gap_done)
						state <= memtest_pkg::WRITE;
				end
				memtest_pkg::WAIT_GAP_RD:
				begin
					if (gap_done)
						state <= memtest_pkg::READ;
				end
				memtest_pkg::PASS_END:
				begin
					// Gap after the last read is already running
					if (!run)
						state <= memtest_pkg::IDLE;
					else if (gap_done)
						state <= memtest_pkg::WRITE;
					else
						state <= memtest_pkg::WAIT_GAP_WR;
				end
				default:
					state <= memtest_pkg::IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/memtest_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "memtest_consts.svh"

module memtest_top
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  run,
	input  logic                  mem_ready,
	input  memtest_pkg::line_t     mem_rdata,
	output logic                  mem_valid,
	output logic                  mem_rw,
	output memtest_pkg::mem_addr_t mem_addr,
	output memtest_pkg::line_t     mem_wdata,
	output logic                  pass_done,
	output logic                  error,
	output memtest_pkg::mem_addr_t fail_addr
);

	logic                   timer_start;
	logic                   gap_done;
	logic                   read_done;
	memtest_pkg::line_idx_t line_idx;
	memtest_pkg::line_t     pattern;

	// Line i sits at i * stride
	assign mem_addr  = memtest_pkg::mem_addr_t'(line_idx) *
		memtest_pkg::mem_addr_t'(`MEMTEST_STRIDE);
	assign mem_wdata = pattern;

	////////////////////////////////////////////////////////////
	// Sequencer and gap timer
	////////////////////////////////////////////////////////////

	memtest_fsm u_memtest_fsm (
		.clk         (clk),
		.rst         (rst),
		.run         (run),
		.mem_ready   (mem_ready),
		.gap_done    (gap_done),
		.timer_start (timer_start),
		.mem_valid   (mem_valid),
		.mem_rw      (mem_rw),
		.line_idx    (line_idx),
		.read_done   (read_done),
		.pass_done   (pass_done)
	);

	gap_timer #(
		.GAP_CYCLES (`MEMTEST_GAP)
	) u_gap_timer (
		.clk         (clk),
		.rst         (rst),
		.timer_start (timer_start),
		.gap_done    (gap_done)
	);

	////////////////////////////////////////////////////////////
	// Data pattern and readback check
	////////////////////////////////////////////////////////////

	pattern_gen u_pattern_gen (
		.line_idx (line_idx),
		.pattern  (pattern)
	);

	// Same pattern serves as write data and reference
	readback_checker u_readback_checker (
		.clk       (clk),
		.rst       (rst),
		.read_done (read_done),
		.rdata     (mem_rdata),
		.expected  (pattern),
		.addr      (mem_addr),
		.error     (error),
		.fail_addr (fail_addr)
	);

endmodule

`default_nettype wire

// File: sim/mem_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "memtest_consts.svh"

module mem_model
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   mem_valid,
	input  logic                   mem_rw,
	input  memtest_pkg::mem_addr_t mem_addr,
	input  memtest_pkg::line_t     mem_wdata,
	input  logic [4:0]             bad_line,
	output logic                   mem_ready,
	output memtest_pkg::line_t     mem_rdata
);

	localparam int DEPTH = 256;
	localparam int WORDS = `MEMTEST_DATA_W / 32;

	memtest_pkg::line_t lines [DEPTH];
	memtest_pkg::mem_addr_t bad_addr;
	logic [15:0] lfsr;
	logic [1:0]  delay;
	logic [1:0]  wait_cnt;
	logic        started;

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// Stored line, bit 0 flipped on the faulty line
	function automatic memtest_pkg::line_t fetch_line(input memtest_pkg::mem_addr_t addr);
		memtest_pkg::line_t data;
		data = lines[addr[7:0]];
		if (addr == bad_addr)
			data[0] = ~data[0];
		return data;
	endfunction

	assign bad_addr = memtest_pkg::mem_addr_t'(bad_line) *
		memtest_pkg::mem_addr_t'(`MEMTEST_STRIDE);

	initial
	begin
		mem_ready = 1'b0;
		mem_rdata = '0;
		started   = 1'b0;
		wait_cnt  = 2'd0;
		delay     = 2'd0;
		lfsr      = 16'd60;
		// Unwritten lines carry their own address
		for (int i = 0; i < DEPTH; i++)
			for (int w = 0; w < WORDS; w++)
				lines[8'(i)][w*32 +: 32] = 32'hBAD0_0000 + 32'(i * 16 + w);
		forever
		begin
			@(posedge clk);
			if (!rst && mem_valid && mem_ready && mem_rw)
				lines[mem_addr[7:0]] = mem_wdata;
			@(negedge clk);
			if (rst || !mem_valid)
			begin
				mem_ready = 1'b0;
				started   = 1'b0;
			end
			else if (!started)
			begin
				// Two LFSR bits give a latency of 0 to 3 cycles
				started  = 1'b1;
				lfsr     = lfsr_next(lfsr);
				delay[0] = lfsr[0];
				lfsr     = lfsr_next(lfsr);
				delay[1] = lfsr[0];
				wait_cnt = delay;
				if (delay == 2'd0)
				begin
					mem_ready = 1'b1;
					mem_rdata = fetch_line(mem_addr);
				end
			end
			else if (!mem_ready)
			begin
				if (wait_cnt == 2'd1)
				begin
					mem_ready = 1'b1;
					mem_rdata = fetch_line(mem_addr);
				end
				wait_cnt = wait_cnt - 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/memtest_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "memtest_consts.svh"

module memtest_tb;

	localparam int ROWS       = 5;
	localparam int LINES      = `MEMTEST_LINES;
	localparam int CMDS       = 2 * LINES;
	localparam int CMD_WORST  = 3 + `MEMTEST_GAP + 1;
	localparam int RST_CYCLES = 8;
	localparam int QUIET      = 50;
	localparam logic [4:0] NO_BAD = 5'h1F;

	// Scenario table: faulty line, passes, expected error, expected fail_addr
	logic [4:0] row_bad [ROWS] = '{NO_BAD, 5'd5, 5'd0, 5'd15, NO_BAD};
	int row_passes [ROWS] = '{1, 2, 1, 2, 3};
	logic row_err [ROWS] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
	memtest_pkg::mem_addr_t row_fail [ROWS] = '{28'd0, 28'd40, 28'd0, 28'd120, 28'd0};

	logic                   clk;
	logic                   rst;
	logic                   run;
	logic [4:0]             bad_line;
	logic                   mem_ready;
	logic                   mem_valid;
	logic                   mem_rw;
	logic                   pass_done;
	logic                   error;
	memtest_pkg::line_t     mem_rdata;
	memtest_pkg::line_t     mem_wdata;
	memtest_pkg::mem_addr_t mem_addr;
	memtest_pkg::mem_addr_t fail_addr;

	// Monitor state
	int  cycles = 0;
	int  limit = 0;
	int  pass_cnt = 0;
	int  cmd_cnt = 0;
	int  gap_cnt = 0;
	int  err_rises = 0;
	bit  gap_armed = 1'b0;
	logic prev_valid = 1'b0;
	logic prev_ready = 1'b0;
	logic prev_rw = 1'b0;
	logic prev_error = 1'b0;
	memtest_pkg::mem_addr_t prev_addr = '0;
	memtest_pkg::mem_addr_t prev_fail = '0;
	memtest_pkg::line_t     prev_wdata = '0;

	memtest_top u_memtest_top (
		.clk       (clk),
		.rst       (rst),
		.run       (run),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata),
		.mem_valid (mem_valid),
		.mem_rw    (mem_rw),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.pass_done (pass_done),
		.error     (error),
		.fail_addr (fail_addr)
	);

	mem_model u_mem_model (
		.clk       (clk),
		.rst       (rst),
		.mem_valid (mem_valid),
		.mem_rw    (mem_rw),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.bad_line  (bad_line),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
			$display("Test failures found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Word j of line i is seed[i mod 4] + i*256 + j
	function automatic memtest_pkg::line_t expected_line(input int line);
		memtest_pkg::line_t data;
		logic [1:0]         sel;
		sel = 2'(line % 4);
		for (int j = 0; j < `MEMTEST_DATA_W / 32; j++)
			data[j*32 +: 32] = memtest_pkg::PATTERN_SEEDS[sel] + 32'(line * 256 + j);
		return data;
	endfunction

	// Writes of lines 0 to 15 come first, then reads of the same lines
	task automatic check_command();
		int line;
		line = cmd_cnt % LINES;
		check_value("mem_rw", 256'(mem_rw), 256'(cmd_cnt < LINES));
		check_value("mem_addr", 256'(mem_addr), 256'(line * `MEMTEST_STRIDE));
		if (mem_rw)
			check_value("mem_wdata", mem_wdata, expected_line(line));
	endtask

	////////////////////////////////////////////////////////////
	// Bus monitor, sampled on the edge the DUT uses
	////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (rst)
		begin
			pass_cnt  = 0;
			cmd_cnt   = 0;
			gap_cnt   = 0;
			err_rises = 0;
			gap_armed = 1'b0;
		end
		else
		begin
			// Stalled command must not move
			if (prev_valid && !prev_ready)
			begin
				check_value("mem_valid during stall", 256'(mem_valid), 256'(1'b1));
				check_value("mem_rw during stall", 256'(mem_rw), 256'(prev_rw));
				check_value("mem_addr during stall", 256'(mem_addr), 256'(prev_addr));
				check_value("mem_wdata during stall", mem_wdata, prev_wdata);
			end
			if (mem_valid && gap_armed)
			begin
				check_value("idle cycles between commands", 256'(gap_cnt),
					256'(`MEMTEST_GAP));
				gap_armed = 1'b0;
			end
			else if (!mem_valid)
				gap_cnt++;
			if (mem_valid && mem_ready)
			begin
				check_command();
				cmd_cnt++;
				gap_cnt   = 0;
				gap_armed = 1'b1;
			end
			if (pass_done)
			begin
				check_value("commands per pass", 256'(cmd_cnt), 256'(CMDS));
				cmd_cnt = 0;
				pass_cnt++;
			end
			// First failure stays latched
			if (error && !prev_error)
				err_rises++;
			if (prev_error)
				check_value("fail_addr after error", 256'(fail_addr), 256'(prev_fail));
		end
		prev_valid = mem_valid;
		prev_ready = mem_ready;
		prev_rw    = mem_rw;
		prev_addr  = mem_addr;
		prev_wdata = mem_wdata;
		prev_error = error;
		prev_fail  = fail_addr;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("Test failures found");
			$fatal(1, "Timeout: the run did not finish within %0d cycles", limit);
		end
	end

	////////////////////////////////////////////////////////////
	// Scenario sequencing
	////////////////////////////////////////////////////////////

	task automatic run_scenario(input int r);
		@(negedge clk);
		rst      = 1'b1;
		run      = 1'b0;
		bad_line = row_bad[r];
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		run = 1'b1;
		// Later passes corrupt the neighbouring line at another address
		if (row_passes[r] > 1)
		begin
			while (pass_cnt < 1)
				@(negedge clk);
			bad_line = row_bad[r] ^ 5'd1;
		end
		// Drop run part way into the last pass
		while (!(pass_cnt == row_passes[r] - 1 && cmd_cnt >= 8))
			@(negedge clk);
		run = 1'b0;
		while (pass_cnt < row_passes[r])
			@(negedge clk);
		repeat (QUIET)
		begin
			@(negedge clk);
			check_value("mem_valid after run dropped", 256'(mem_valid), 256'(1'b0));
		end
		check_value("pass_done count", 256'(pass_cnt), 256'(row_passes[r]));
		check_value("error", 256'(error), 256'(row_err[r]));
		check_value("fail_addr", 256'(fail_addr), 256'(row_fail[r]));
		check_value("error rising edges", 256'(err_rises), 256'(row_err[r]));
	endtask

	initial
	begin
		rst      = 1'b1;
		run      = 1'b0;
		bad_line = NO_BAD;
		for (int r = 0; r < ROWS; r++)
			limit += 4 * (row_passes[r] * CMDS * CMD_WORST + RST_CYCLES + QUIET + 8);
		for (int r = 0; r < ROWS; r++)
			run_scenario(r);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+design
design/memtest_pkg.sv
design/gap_timer.sv
design/pattern_gen.sv
design/readback_checker.sv
design/memtest_fsm.sv
design/memtest_top.sv
sim/mem_model.sv
sim/memtest_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
	-f compile.f --top-module memtest_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vmemtest_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished cleanly"
exit 0
